/* logic/status_read_pkg.sv */
package status_read_pkg;

    // Word and address widths of the debug readback path.
    localparam int STATUS_W = 32;
    localparam int ADDR_W   = 9;

    // The status window is split into groups of sixteen words.
    // Address bits 3:0 pick the word in a group and bits 6:4 pick the group.
    localparam int WORDS_PER_GROUP = 16;
    localparam int GROUP_CNT       = 8;
    localparam int STATUS_CNT      = GROUP_CNT * WORDS_PER_GROUP;

    // Stage 1 reduces each group to one word per even/odd pair.
    localparam int PAIR_CNT = WORDS_PER_GROUP / 2;

    // Value of address bits 8:4 for the first group, i.e. word address 0x080.
    localparam logic [ADDR_W-5:0] STATUS_BASE_GROUP = 5'h08;

    typedef logic [STATUS_W-1:0] status_word_t;

    typedef logic [ADDR_W-1:0] status_addr_t;

    // Word n of the bank is read at address 0x080 + n.
    typedef status_word_t [STATUS_CNT-1:0] status_bank_t;

    // One word per group, the output of the second stage.
    typedef status_word_t [GROUP_CNT-1:0] group_words_t;

    // Single-cycle enables that walk a request through the three stages.
    typedef struct packed {
        logic stage1_en;
        logic stage2_en;
        logic lock_en;
    } pipe_ctl_t;

endpackage

/* logic/req_toggle_sync.sv */
`timescale 1ns/100ps

module req_toggle_sync
(
    input  logic                       core_clk,
    input  logic                       core_rst_n,
    input  logic                       rd_req,
    output status_read_pkg::pipe_ctl_t pipe_ctl,
    output logic                       rd_ack
);

    logic req_sync1;
    logic req_sync2;
    logic req_sync3;
    logic req_edge;
    logic req_edge_d1;
    logic req_edge_d2;

    // rd_req is launched from the debug port clock.
    // The first flop may go metastable, the second settles it.
    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
        begin
            req_sync1 <= 1'b0;
            req_sync2 <= 1'b0;
            req_sync3 <= 1'b0;
        end
        else
        begin
            req_sync1 <= rd_req;
            req_sync2 <= req_sync1;
            req_sync3 <= req_sync2;
        end
    end

    // A request is a change of level in either direction.
    assign req_edge = req_sync3 ^ req_sync2;

    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
        begin
            req_edge_d1 <= 1'b0;
            req_edge_d2 <= 1'b0;
        end
        else
        begin
            req_edge_d1 <= req_edge;
            req_edge_d2 <= req_edge_d1;
        end
    end

    // The lock register loads on the same edge, so lock_data is stable
    // before the requester sees the acknowledge.
    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
            rd_ack <= 1'b0;
        else if (req_edge_d2)
            rd_ack <= ~rd_ack;
    end

    assign pipe_ctl = '{
        stage1_en: req_edge,
        stage2_en: req_edge_d1,
        lock_en:   req_edge_d2
    };

    // Only one request is in flight, so the stages never overlap.
    a_stages_apart: assert property (@(posedge core_clk) disable iff (!core_rst_n)
        $onehot0({pipe_ctl.stage1_en, pipe_ctl.stage2_en, pipe_ctl.lock_en}));

    // The acknowledge may only move once the lock register has loaded,
    // and then it takes the level of the synchronized request.
    a_ack_after_lock: assert property (@(posedge core_clk) disable iff (!core_rst_n)
        $changed(rd_ack) |-> ($past(pipe_ctl.lock_en) && (rd_ack == req_sync3)));

endmodule

/* logic/status_column_select.sv */
`timescale 1ns/100ps

module status_column_select
(
    input  logic                          core_clk,
    input  logic                          core_rst_n,
    input  status_read_pkg::pipe_ctl_t    pipe_ctl,
    input  status_read_pkg::status_addr_t rd_addr,
    input  status_read_pkg::status_bank_t status_bank,
    output status_read_pkg::group_words_t group_words
);

    localparam int GROUPS     = status_read_pkg::GROUP_CNT;
    localparam int PAIRS      = status_read_pkg::PAIR_CNT;
    localparam int GROUP_SIZE = status_read_pkg::WORDS_PER_GROUP;

    // Stage 1 result, one word for every pair of every group.
    status_read_pkg::status_word_t [GROUPS-1:0][PAIRS-1:0] pair_words;

    logic       odd_sel;
    logic [2:0] pair_sel;

    // The address is held by the requester for the whole request.
    assign odd_sel  = rd_addr[0];
    assign pair_sel = rd_addr[3:1];

    // Stage 1 keeps the even or the odd word of each pair.
    // Bank word g*16 + 2*p is the even word of pair p in group g.
    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
        begin
            pair_words <= '0;
        end
        else if (pipe_ctl.stage1_en)
        begin
            for (int g = 0; g < GROUPS; g++)
            begin
                for (int p = 0; p < PAIRS; p++)
                begin
                    if (odd_sel)
                        pair_words[g][p] <= status_bank[g * GROUP_SIZE + 2 * p + 1];
                    else
                        pair_words[g][p] <= status_bank[g * GROUP_SIZE + 2 * p];
                end
            end
        end
    end

    // Stage 2 picks one of the eight pair words in each group.
    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
        begin
            group_words <= '0;
        end
        else if (pipe_ctl.stage2_en)
        begin
            for (int g = 0; g < GROUPS; g++)
            begin
                group_words[g] <= pair_words[g][pair_sel];
            end
        end
    end

endmodule

/* logic/status_lock_reg.sv */
`timescale 1ns/100ps

module status_lock_reg
(
    input  logic                          core_clk,
    input  logic                          core_rst_n,
    input  status_read_pkg::pipe_ctl_t    pipe_ctl,
    input  status_read_pkg::status_addr_t rd_addr,
    input  status_read_pkg::group_words_t group_words,
    output status_read_pkg::status_word_t lock_data
);

    localparam logic [status_read_pkg::ADDR_W-5:0] FIRST_GROUP =
        status_read_pkg::STATUS_BASE_GROUP;
    localparam logic [status_read_pkg::ADDR_W-5:0] LAST_GROUP =
        FIRST_GROUP + (status_read_pkg::ADDR_W - 4)'(status_read_pkg::GROUP_CNT - 1);

    logic [status_read_pkg::ADDR_W-1:4] group_field;
    logic [2:0]                         group_sel;
    logic                               in_range;

    assign group_field = rd_addr[status_read_pkg::ADDR_W-1:4];
    assign group_sel   = rd_addr[6:4];

    // Only the window 0x080 to 0x0FF maps onto the status bank.
    assign in_range = (group_field >= FIRST_GROUP) && (group_field <= LAST_GROUP);

    // Out of range reads lock zero so the port never returns stale data.
    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
        begin
            lock_data <= '0;
        end
        else if (pipe_ctl.lock_en)
        begin
            if (in_range)
                lock_data <= group_words[group_sel];
            else
                lock_data <= '0;
        end
    end

    // An address outside the window must never leak a group word.
    a_out_of_range_zero: assert property (@(posedge core_clk) disable iff (!core_rst_n)
        (pipe_ctl.lock_en && ((rd_addr < 9'h080) || (rd_addr > 9'h0FF)))
        |=> (lock_data == '0));

endmodule

/* logic/status_read_top.sv */
`timescale 1ns/100ps

module status_read_top
(
    input  logic                          core_clk,
    input  logic                          core_rst_n,
    input  logic                          rd_req,
    input  status_read_pkg::status_addr_t rd_addr,
    input  status_read_pkg::status_bank_t status_bank,
    output logic                          rd_ack,
    output status_read_pkg::status_word_t lock_data
);

    status_read_pkg::pipe_ctl_t    pipe_ctl;
    status_read_pkg::group_words_t group_words;

    // Brings the request toggle into core_clk and sequences the stages.
    req_toggle_sync u_req_sync
    (
        .core_clk    (core_clk),
        .core_rst_n  (core_rst_n),
        .rd_req      (rd_req),
        .pipe_ctl    (pipe_ctl),
        .rd_ack      (rd_ack)
    );

    // First two selection stages, one word left per group.
    status_column_select u_column_select
    (
        .core_clk    (core_clk),
        .core_rst_n  (core_rst_n),
        .pipe_ctl    (pipe_ctl),
        .rd_addr     (rd_addr),
        .status_bank (status_bank),
        .group_words (group_words)
    );

    // Last stage with the range check, holds the word for the requester.
    status_lock_reg u_lock_reg
    (
        .core_clk    (core_clk),
        .core_rst_n  (core_rst_n),
        .pipe_ctl    (pipe_ctl),
        .rd_addr     (rd_addr),
        .group_words (group_words),
        .lock_data   (lock_data)
    );

endmodule

/* tests/status_read_tasks.svh */
`ifndef STATUS_READ_TASKS_SVH
`define STATUS_READ_TASKS_SVH

task automatic check_value(input string test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual)
    begin
        $display("** Error [%s]: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
        $display("** FAIL **");
        $fatal(1, "Stopped at the first mismatch.");
    end
endtask

// Inputs change a short delay after the rising edge, away from the sampling point.
task automatic next_drive_slot();
    @(posedge core_clk);
    #DRIVE_DELAY;
endtask

task automatic fill_random_bank();
    for (int i = 0; i < status_read_pkg::STATUS_CNT; i++)
    begin
        status_bank[7'(i)] = $urandom();
    end
endtask

// Word n of the bank answers at 0x080 + n, every other address reads zero.
function automatic status_read_pkg::status_word_t expected_word(
    input status_read_pkg::status_addr_t addr,
    input status_read_pkg::status_bank_t bank
);
    logic [6:0] word_idx;
    if (addr >= 9'h080 && addr <= 9'h0FF)
    begin
        word_idx = 7'(addr - 9'h080);
        return bank[word_idx];
    end
    return '0;
endfunction

task automatic read_status(input status_read_pkg::status_addr_t addr,
                           output status_read_pkg::status_word_t data);
    rd_addr = addr;
    rd_req  = ~rd_req;
    while (rd_ack !== rd_req)
    begin
        next_drive_slot();
    end
    data = lock_data;
endtask

task automatic test_reset_values();
    check_value("reset_values", 32'h0, 32'(rd_ack));
    check_value("reset_values", 32'h0, lock_data);
endtask

task automatic test_single_read_timing();
    logic                          ack_before;
    logic                          ack_after;
    status_read_pkg::status_word_t data_before;
    next_drive_slot();
    fill_random_bank();
    ack_before  = rd_ack;
    ack_after   = ~rd_ack;
    data_before = lock_data;
    rd_addr     = 9'h080;
    rd_req      = ~rd_req;
    // Edge 1 is the first edge that samples the new request level.
    for (int edge_num = 1; edge_num <= 5; edge_num++)
    begin
        next_drive_slot();
        if (edge_num < 5)
        begin
            check_value("single_read_timing", 32'(ack_before), 32'(rd_ack));
            check_value("single_read_timing", data_before, lock_data);
        end
        else
        begin
            check_value("single_read_timing", 32'(ack_after), 32'(rd_ack));
        end
    end
    check_value("single_read_timing", expected_word(9'h080, status_bank), lock_data);
endtask

task automatic test_address_sweep();
    status_read_pkg::status_addr_t addr;
    status_read_pkg::status_word_t data;
    fill_random_bank();
    for (int n = 0; n < status_read_pkg::STATUS_CNT; n++)
    begin
        addr = 9'h080 + 9'(n);
        read_status(addr, data);
        check_value("address_sweep", expected_word(addr, status_bank), data);
    end
endtask

task automatic test_out_of_range();
    status_read_pkg::status_addr_t bad_addrs[4];
    status_read_pkg::status_word_t data;
    bad_addrs = '{9'h000, 9'h07F, 9'h100, 9'h1FF};
    fill_random_bank();
    foreach (bad_addrs[i])
    begin
        // A valid read first, so a zero result cannot be left over.
        read_status(9'h0A5, data);
        check_value("out_of_range", expected_word(9'h0A5, status_bank), data);
        read_status(bad_addrs[i], data);
        check_value("out_of_range", 32'h0, data);
    end
endtask

task automatic test_hold_without_request();
    status_read_pkg::status_word_t old_data;
    logic                          old_ack;
    fill_random_bank();
    read_status(9'h0C3, old_data);
    check_value("hold_without_request", expected_word(9'h0C3, status_bank), old_data);
    old_ack = rd_ack;
    fill_random_bank();
    repeat (20)
    begin
        next_drive_slot();
        check_value("hold_without_request", old_data, lock_data);
        check_value("hold_without_request", 32'(old_ack), 32'(rd_ack));
    end
endtask

task automatic test_back_to_back();
    status_read_pkg::status_addr_t addr;
    status_read_pkg::status_word_t data;
    repeat (10)
    begin
        fill_random_bank();
        // Window around 0x080 to 0x0FF so both in and out of range reads occur.
        addr = status_read_pkg::status_addr_t'($urandom_range('h13F, 'h040));
        read_status(addr, data);
        check_value("back_to_back", expected_word(addr, status_bank), data);
    end
endtask

`endif

/* tests/status_read_tb.sv */
`timescale 1ns/100ps

module status_read_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY  = 1;

    // About 150 requests of at most 10 cycles each, plus the 20 idle cycles
    // of the hold test and the reset, with a wide margin.
    localparam int TIMEOUT_CYCLES = 2000;

    logic                          core_clk;
    logic                          core_rst_n;
    logic                          rd_req;
    status_read_pkg::status_addr_t rd_addr;
    status_read_pkg::status_bank_t status_bank;
    logic                          rd_ack;
    status_read_pkg::status_word_t lock_data;

    int cycle_count = 0;

    status_read_top uut
    (
        .core_clk    (core_clk),
        .core_rst_n  (core_rst_n),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .status_bank (status_bank),
        .rd_ack      (rd_ack),
        .lock_data   (lock_data)
    );

    initial
    begin
        core_clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) core_clk = ~core_clk;

    // Guards against a request that never gets its acknowledge.
    always @(posedge core_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "Simulation stopped by the cycle limit.");
        end
    end

    `include "status_read_tasks.svh"

    initial
    begin
        void'($urandom(32'he74a));

        core_rst_n  = 1'b0;
        rd_req      = 1'b0;
        rd_addr     = '0;
        status_bank = '0;

        repeat (RESET_CYCLES) @(posedge core_clk);
        #DRIVE_DELAY;
        core_rst_n = 1'b1;

        test_reset_values();
        test_single_read_timing();
        test_address_sweep();
        test_out_of_range();
        test_hold_without_request();
        test_back_to_back();

        $display("** PASS **");
        $finish;
    end

endmodule

/* flist.f */
+incdir+tests
logic/status_read_pkg.sv
logic/req_toggle_sync.sv
logic/status_column_select.sv
logic/status_lock_reg.sv
logic/status_read_top.sv
tests/status_read_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=status_read_sim
LOG_FILE=sim.log

# The package carries no timescale, so the default unit is given here.
verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module status_read_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN" \
    -f flist.f

# The simulator exits non-zero on $fatal, the log decides the result.
"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -qF "** FAIL **" "$LOG_FILE"; then
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi

if ! grep -qF "** PASS **" "$LOG_FILE"; then
    echo "Simulation ended without a result, see $LOG_FILE"
    exit 1
fi

echo "Simulation passed"
